/* vlog.f */
+incdir+include
hdl/pktgen_pkg.sv
hdl/pktgen_csr.sv
hdl/pktgen_sequencer.sv
hdl/pktgen_payload.sv
hdl/pktgen_top.sv
sim/pktgen_asserts.sv
sim/pktgen_tb.sv

/* Makefile */
# Verilator build and run for the packet generator testbench

VERILATOR ?= verilator
TOP       ?= pktgen_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wall -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -qF '*** TEST FAILED ***' $(LOG); then exit 1; fi
	@if ! grep -qF '*** TEST PASSED ***' $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* sim/pktgen_tb.sv */
// --------------------
// Testbench for the packet generator. Runs a table of packet runs
// against a reference model of the packet layout and payload patterns.
// --------------------
`include "pktgen_macros.svh"

module pktgen_tb;

   import pktgen_pkg::*;

   typedef struct {
      int unsigned len;         // Programmed packet length
      int unsigned npkts;
      bit          rnd;         // PRBS payload
      bit          bp;          // Random tx_ready
      int unsigned stop_after;  // Eops seen before stop or 0 for none
   } row_t;

   localparam int NROWS = 6;
   localparam mac_addr_t DA = 48'h0011_2233_4455;
   localparam mac_addr_t SA = 48'hA0B1_C2D3_E4F5;

   logic      clk;
   logic      reset;
   csr_addr_t address;
   logic      write;
   logic      read;
   csr_data_t writedata;
   csr_data_t readdata;
   logic      tx_ready;
   word_t     tx_data;
   logic      tx_valid;
   logic      tx_sop;
   logic      tx_eop;
   empty_t    tx_empty;

   row_t       rows [NROWS];
   prbs_seed_t seed_model;

   pktgen_top i_pktgen_top (.*);

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // Stimulus table with one run per row
   initial begin
      rows[0] = '{64,   3,  1'b0, 1'b0, 0};   // Incrementing, no stalls
      rows[1] = '{100,  4,  1'b0, 1'b1, 0};   // Back-pressure
      rows[2] = '{60,   3,  1'b1, 1'b1, 0};   // PRBS with written seed
      rows[3] = '{10,   3,  1'b0, 1'b0, 0};   // Header only packets
      rows[4] = '{9700, 1,  1'b0, 1'b1, 0};   // Clamped length
      rows[5] = '{200,  50, 1'b0, 1'b0, 2};   // Stop mid-run
   end

   function automatic int unsigned payload_bytes(input int unsigned len);
      if (len < 20)
         return 0;
      return ((len > 9600) ? 9600 : len) - 20;
   endfunction

   function automatic int unsigned beats_for(input int unsigned len);
      return 2 + (payload_bytes(len) + 7) / 8;
   endfunction

   // One PRBS23 step as a right shift with new top bit = bit 18 ^ bit 0
   function automatic logic [22:0] lane_step(input logic [22:0] s);
      return {s[18] ^ s[0], s[22:1]};
   endfunction

   task automatic report_error(input string msg);
      $display("[FAIL] %0t: %s", $time, msg);
      $display("*** TEST FAILED ***");
      $fatal(1, "Check failed");
   endtask

   task automatic csr_write(input csr_addr_t a, input csr_data_t d);
      @(posedge clk);
      address   <= a;
      writedata <= d;
      write     <= 1'b1;
      @(posedge clk);
      write     <= 1'b0;
   endtask

   task automatic csr_read(input csr_addr_t a, output csr_data_t d);
      @(posedge clk);
      address <= a;
      read    <= 1'b1;
      @(posedge clk);
      read    <= 1'b0;
      @(negedge clk);
      d = readdata;                         // Registered the cycle after read
   endtask

   task automatic check_reg(input csr_addr_t a, input csr_data_t exp);
      csr_data_t rd;
      csr_read(a, rd);
      assert (rd == exp)
         else report_error($sformatf("reg 0x%0h read 0x%0h, expected 0x%0h", a, rd, exp));
   endtask

   // --------------------
   // One run programs, starts and checks every beat against the model
   // --------------------
   task automatic run_row(input row_t r);
      int unsigned p;
      int unsigned nbeats;
      int unsigned beat;
      int unsigned pkt;
      int unsigned eops;
      int unsigned idle;
      bit          stop_sent;
      bit          done;
      word_t       exp_data;
      logic        exp_sop;
      logic        exp_eop;
      empty_t      exp_empty;
      word_t       inc;
      prbs_seed_t  lanes;
      csr_data_t   rd;
      p      = payload_bytes(r.len);
      nbeats = beats_for(r.len);
      csr_write(`PKTGEN_ADDR_PKTLEN, r.len);
      csr_write(`PKTGEN_ADDR_NUMPKTS, r.npkts);
      csr_write(`PKTGEN_ADDR_RANDPAYLOAD, r.rnd);
      csr_write(`PKTGEN_ADDR_START, 32'd1);
      inc       = `PKTGEN_INC_FIRST;        // Patterns restart on each start
      lanes     = seed_model;
      beat      = 0;
      pkt       = 0;
      eops      = 0;
      idle      = 0;
      stop_sent = 0;
      done      = 0;
      while (!done) begin
         @(posedge clk);
         tx_ready <= r.bp ? ($urandom_range(3) != 0) : 1'b1;
         write    <= 1'b0;
         if (r.stop_after != 0 && eops >= r.stop_after && !stop_sent) begin
            address   <= `PKTGEN_ADDR_STOP;
            writedata <= 32'd1;
            write     <= 1'b1;
            stop_sent = 1;
         end
         @(negedge clk);
         if (tx_valid && tx_ready) begin
            idle      = 0;
            exp_sop   = (beat == 0);
            exp_eop   = 1'b0;
            exp_empty = '0;
            if (beat == 0) begin
               exp_data = {DA, SA[47:32]};
            end else if (beat == 1) begin
               exp_data = {SA[31:0], 16'(p + 2), 16'(pkt)};
               exp_eop  = (p == 0);
            end else begin
               exp_data = r.rnd ? lanes[63:0] : inc;
               exp_eop  = (beat == nbeats - 1);
               if (exp_eop)
                  exp_empty = 3'((8 - p % 8) % 8);
               if (r.rnd) begin
                  for (int k = 0; k < 23; k++)
                     for (int i = 0; i < 4; i++)
                        lanes[23*i +: 23] = lane_step(lanes[23*i +: 23]);
               end else begin
                  inc = (inc == `PKTGEN_INC_LAST) ? `PKTGEN_INC_FIRST : inc + `PKTGEN_INC_STEP;
               end
            end
            assert (tx_data == exp_data && tx_sop == exp_sop && tx_eop == exp_eop &&
                    tx_empty == exp_empty)
               else report_error($sformatf("pkt %0d beat %0d got %h/%b%b/%0d exp %h/%b%b/%0d",
                                 pkt, beat, tx_data, tx_sop, tx_eop, tx_empty,
                                 exp_data, exp_sop, exp_eop, exp_empty));
            beat++;
            if (exp_eop) begin
               eops++;
               pkt++;
               beat = 0;
            end
         end else begin
            idle++;
         end
         // Stopped runs end once the stream has gone quiet
         done = (r.stop_after == 0) ? (eops == r.npkts) : (stop_sent && idle >= 64);
      end
      @(posedge clk);
      tx_ready <= 1'b1;
      csr_read(`PKTGEN_ADDR_TXPKTCNT, rd);
      assert (rd == eops)
         else report_error($sformatf("TXPKTCNT %0d, eop beats seen %0d", rd, eops));
      if (r.stop_after != 0) begin
         // Packet in progress when stop lands still completes
         assert (eops == r.stop_after + 1)
            else report_error($sformatf("stop after %0d eops gave %0d packets, expected %0d",
                              r.stop_after, eops, r.stop_after + 1));
         csr_write(`PKTGEN_ADDR_STOP, 32'd0);
      end
   endtask

   // Watchdog sized from the table
   initial begin
      longint limit;
      #1;
      limit = 5000;                          // Register traffic and idle tails
      for (int i = 0; i < NROWS; i++)
         limit += 20 * rows[i].npkts * beats_for(rows[i].len);
      repeat (limit) @(posedge clk);
      $display("Timeout: run did not finish within %0d cycles", limit);
      $display("*** TEST FAILED ***");
      $fatal(1, "Watchdog expired");
   end

   initial begin
      void'($urandom(32'h680b));
      reset     = 1'b1;
      address   = '0;
      write     = 1'b0;
      read      = 1'b0;
      writedata = '0;
      tx_ready  = 1'b1;
      repeat (4) @(posedge clk);
      reset <= 1'b0;

      // Reset values, then read-back of written registers
      check_reg(`PKTGEN_ADDR_SEED0, `PKTGEN_SEED0_RST);
      check_reg(`PKTGEN_ADDR_SEED1, `PKTGEN_SEED1_RST);
      check_reg(`PKTGEN_ADDR_SEED2, `PKTGEN_SEED2_RST);
      check_reg(`PKTGEN_ADDR_TXPKTCNT, 32'd0);
      csr_write(`PKTGEN_ADDR_MACDA0, DA[31:0]);
      csr_write(`PKTGEN_ADDR_MACDA1, 32'(DA[47:32]));
      csr_write(`PKTGEN_ADDR_MACSA0, SA[31:0]);
      csr_write(`PKTGEN_ADDR_MACSA1, 32'(SA[47:32]));
      check_reg(`PKTGEN_ADDR_MACDA0, DA[31:0]);
      check_reg(`PKTGEN_ADDR_MACDA1, 32'(DA[47:32]));
      check_reg(`PKTGEN_ADDR_MACSA0, SA[31:0]);
      check_reg(`PKTGEN_ADDR_MACSA1, 32'(SA[47:32]));
      seed_model = {28'(`PKTGEN_SEED2_RST), `PKTGEN_SEED1_RST, `PKTGEN_SEED0_RST};

      for (int i = 0; i < NROWS; i++) begin
         if (rows[i].rnd) begin
            csr_write(`PKTGEN_ADDR_SEED0, 32'h1234_5678);
            csr_write(`PKTGEN_ADDR_SEED1, 32'h9ABC_DEF0);
            csr_write(`PKTGEN_ADDR_SEED2, 32'h0FED_CBA9);
            seed_model = {28'hFED_CBA9, 32'h9ABC_DEF0, 32'h1234_5678};
         end
         run_row(rows[i]);
      end

      $display("*** TEST PASSED ***");
      $finish;
   end

endmodule

/* sim/pktgen_asserts.sv */
// --------------------
// Stream protocol checks on the packet generator output.
// Bound to the top level from here.
// --------------------
module pktgen_asserts (
   input logic                 clk,
   input logic                 reset,
   input logic                 tx_ready,
   input pktgen_pkg::word_t    tx_data,
   input logic                 tx_valid,
   input logic                 tx_sop,
   input logic                 tx_eop,
   input pktgen_pkg::empty_t   tx_empty
);

   // Stalled beat must hold
   a_hold: assert property (@(posedge clk) disable iff (reset)
      tx_valid && !tx_ready |=> tx_valid && $stable(tx_data) && $stable(tx_sop) &&
      $stable(tx_eop) && $stable(tx_empty))
      else $error("Stream output changed while stalled");

   a_marks: assert property (@(posedge clk) disable iff (reset)
      (tx_sop || tx_eop) |-> tx_valid)   // Framing bits need a valid beat
      else $error("sop or eop without valid");

   a_empty: assert property (@(posedge clk) disable iff (reset)
      tx_valid && !tx_eop |-> tx_empty == '0)
      else $error("Nonzero empty on a beat without eop");

endmodule

bind pktgen_top pktgen_asserts i_asserts (.*);

/* hdl/pktgen_top.sv */
// --------------------
// Test packet generator top level. Register port in, 64-bit
// valid/ready packet stream out.
// --------------------
module pktgen_top (
   input  logic                  clk,
   input  logic                  reset,
   // Register port
   input  pktgen_pkg::csr_addr_t address,
   input  logic                  write,
   input  logic                  read,
   input  pktgen_pkg::csr_data_t writedata,
   output pktgen_pkg::csr_data_t readdata,
   // Stream port
   input  logic                  tx_ready,
   output pktgen_pkg::word_t     tx_data,
   output logic                  tx_valid,
   output logic                  tx_sop,
   output logic                  tx_eop,
   output pktgen_pkg::empty_t    tx_empty
);

   import pktgen_pkg::*;

   gen_cfg_t  cfg;
   beat_cmd_t cmd;
   logic      cmd_valid;
   logic      cmd_ready;
   logic      start;
   logic      stop;
   logic      pkt_done;

   pktgen_csr i_csr (
      .clk       (clk),
      .reset     (reset),
      .address   (address),
      .write     (write),
      .read      (read),
      .writedata (writedata),
      .readdata  (readdata),
      .pkt_done  (pkt_done),
      .cfg       (cfg),
      .start     (start),
      .stop      (stop)
   );

   pktgen_sequencer i_sequencer (
      .clk       (clk),
      .reset     (reset),
      .start     (start),
      .stop      (stop),
      .cfg       (cfg),
      .cmd       (cmd),
      .cmd_valid (cmd_valid),
      .cmd_ready (cmd_ready)
   );

   pktgen_payload i_payload (
      .clk       (clk),
      .reset     (reset),
      .cfg       (cfg),
      .cmd       (cmd),
      .cmd_valid (cmd_valid),
      .cmd_ready (cmd_ready),
      .tx_ready  (tx_ready),
      .tx_data   (tx_data),
      .tx_valid  (tx_valid),
      .tx_sop    (tx_sop),
      .tx_eop    (tx_eop),
      .tx_empty  (tx_empty),
      .pkt_done  (pkt_done)
   );

endmodule

/* hdl/pktgen_payload.sv */
// --------------------
// Output stage. Registers each beat command onto the stream port,
// filling data beats from the incrementing or PRBS23 pattern.
// --------------------
`include "pktgen_macros.svh"

module pktgen_payload (
   input  logic                  clk,
   input  logic                  reset,
   input  pktgen_pkg::gen_cfg_t  cfg,
   input  pktgen_pkg::beat_cmd_t cmd,
   input  logic                  cmd_valid,
   output logic                  cmd_ready,
   input  logic                  tx_ready,
   output pktgen_pkg::word_t     tx_data,
   output logic                  tx_valid,
   output logic                  tx_sop,
   output logic                  tx_eop,
   output pktgen_pkg::empty_t    tx_empty,
   output logic                  pkt_done
);

   import pktgen_pkg::*;

   logic       cmd_move;
   word_t      inc_word;   // Incrementing pattern
   prbs_seed_t lanes;      // Four PRBS23 lanes
   prbs_seed_t lanes_nxt;

   // x^23 + x^18 + 1, advanced 23 steps at once
   function automatic logic [22:0] prbs23_adv(input logic [22:0] lane);
      logic [22:0] s;
      s = lane;
      for (int k = 0; k < 23; k++) begin
         s = {s[18] ^ s[0], s[22:1]};
      end
      return s;
   endfunction

   always_comb begin
      for (int i = 0; i < 4; i++) begin
         lanes_nxt[23*i +: 23] = prbs23_adv(lanes[23*i +: 23]);
      end
   end

   assign cmd_ready = !tx_valid || tx_ready;   // Output register empty or draining
   assign cmd_move  = cmd_valid && cmd_ready;
   assign pkt_done  = tx_valid && tx_ready && tx_eop;

   // --------------------
   // Stream control
   // --------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         tx_valid <= 1'b0;
         tx_sop   <= 1'b0;
         tx_eop   <= 1'b0;
         tx_empty <= '0;
      end else if (cmd_move) begin
         tx_valid <= 1'b1;
         tx_sop   <= cmd.sop;
         tx_eop   <= cmd.eop;
         tx_empty <= cmd.empty;
      end else if (tx_ready) begin
         tx_valid <= 1'b0;                        // Beat taken, nothing behind it
         tx_sop   <= 1'b0;
         tx_eop   <= 1'b0;
         tx_empty <= '0;
      end
   end

   // Beat data, header words pass straight through
   always_ff @(posedge clk) begin
      if (cmd_move) begin
         if (!cmd.is_data)
            tx_data <= cmd.hdr_word;
         else if (cfg.random_payload)
            tx_data <= lanes[63:0];                // Lane 0 in the low bits
         else
            tx_data <= inc_word;
      end
   end

   // --------------------
   // Pattern state
   // --------------------
   always_ff @(posedge clk) begin
      if (cmd_move && cmd.run_first) begin
         inc_word <= `PKTGEN_INC_FIRST;            // Fresh pattern each run
         lanes    <= cfg.seed;
      end else if (cmd_move && cmd.is_data) begin
         if (cfg.random_payload)
            lanes <= lanes_nxt;
         else if (inc_word == `PKTGEN_INC_LAST)
            inc_word <= `PKTGEN_INC_FIRST;         // Wrap after FF byte
         else
            inc_word <= inc_word + `PKTGEN_INC_STEP;
      end
   end

endmodule

/* hdl/pktgen_sequencer.sv */
// --------------------
// Packet sequencer. Walks the header and data beats of each packet
// and hands one beat command per cycle to the output stage.
// --------------------
`include "pktgen_macros.svh"

module pktgen_sequencer (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  start,
   input  logic                  stop,
   input  pktgen_pkg::gen_cfg_t  cfg,
   output pktgen_pkg::beat_cmd_t cmd,
   output logic                  cmd_valid,
   input  logic                  cmd_ready
);

   import pktgen_pkg::*;

   seq_state_t  state;
   beat_cmd_t   cmd_nxt;
   logic        advance;     // Command slot free or emptying
   logic        load;
   logic        last_beat;
   logic        run_first;
   pkt_len_t    len_clamp;
   pkt_len_t    p_calc;      // Payload bytes from programmed length
   pkt_len_t    pay_len;     // P of the current packet
   pkt_len_t    rem_bytes;   // Payload bytes still to issue
   seq_num_t    seq_num;
   csr_data_t   pkt_cnt;     // Packets issued this run
   logic [15:0] len_field;
   empty_t      last_empty;

   // --------------------
   // Payload length
   // --------------------
   always_comb begin
      len_clamp = (cfg.pkt_len > `PKTGEN_MAX_LEN) ? `PKTGEN_MAX_LEN : cfg.pkt_len;
      p_calc    = (cfg.pkt_len < `PKTGEN_HDR_BYTES) ? '0 : len_clamp - `PKTGEN_HDR_BYTES;
   end

   assign len_field  = 16'(pay_len) + `PKTGEN_SEQ_BYTES;
   assign last_empty = 3'd0 - pay_len[2:0];        // (8 - P mod 8) mod 8
   assign last_beat  = (rem_bytes <= 14'd8);
   assign advance    = !cmd_valid || cmd_ready;
   assign load       = advance && (state == HDR0 || state == HDR1 || state == DATA);

   // Next beat command
   always_comb begin
      cmd_nxt = '0;
      case (state)
         HDR0: begin
            cmd_nxt.hdr_word  = {cfg.da, cfg.sa[47:32]};
            cmd_nxt.sop       = 1'b1;
            cmd_nxt.run_first = run_first;
         end
         HDR1: begin
            cmd_nxt.hdr_word = {cfg.sa[31:0], len_field, seq_num};
            cmd_nxt.eop      = (pay_len == '0);     // Header only packet
         end
         DATA: begin
            cmd_nxt.is_data = 1'b1;
            cmd_nxt.eop     = last_beat;
            cmd_nxt.empty   = last_beat ? last_empty : 3'd0;
         end
         default: ;
      endcase
   end

   // Command register holds until the output stage takes it
   always_ff @(posedge clk) begin
      if (load)
         cmd <= cmd_nxt;
   end

   // --------------------
   // FSM
   // --------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         state     <= IDLE;
         cmd_valid <= 1'b0;
         run_first <= 1'b0;
         pay_len   <= '0;
         rem_bytes <= '0;
         seq_num   <= '0;
         pkt_cnt   <= '0;
      end else begin
         case (state)
            IDLE: begin
               if (advance) cmd_valid <= 1'b0;     // Last beat of previous run taken
               if (start && cfg.num_packets != '0) begin
                  state     <= HDR0;
                  run_first <= 1'b1;
                  seq_num   <= '0;
                  pkt_cnt   <= '0;
               end
            end
            HDR0: if (advance) begin
               cmd_valid <= 1'b1;
               run_first <= 1'b0;
               pay_len   <= p_calc;                // Length sampled per packet
               rem_bytes <= p_calc;
               pkt_cnt   <= pkt_cnt + 32'd1;
               state     <= HDR1;
            end
            HDR1: if (advance) begin
               cmd_valid <= 1'b1;
               state     <= (pay_len == '0) ? GAP : DATA;
            end
            DATA: if (advance) begin
               cmd_valid <= 1'b1;
               rem_bytes <= last_beat ? '0 : rem_bytes - 14'd8;
               state     <= last_beat ? GAP : DATA;
            end
            GAP: begin
               if (advance) cmd_valid <= 1'b0;
               seq_num <= seq_num + 16'd1;
               state   <= (stop || pkt_cnt >= cfg.num_packets) ? IDLE : HDR0;
            end
            default: state <= IDLE;
         endcase
      end
   end

endmodule

/* hdl/pktgen_csr.sv */
// --------------------
// Register block of the packet generator. Holds the configuration,
// makes the start pulse and counts packets sent since the last start.
// --------------------
`include "pktgen_macros.svh"

module pktgen_csr (
   input  logic                  clk,
   input  logic                  reset,
   input  pktgen_pkg::csr_addr_t address,
   input  logic                  write,
   input  logic                  read,
   input  pktgen_pkg::csr_data_t writedata,
   output pktgen_pkg::csr_data_t readdata,
   input  logic                  pkt_done,  // Eop beat went out
   output pktgen_pkg::gen_cfg_t  cfg,
   output logic                  start,     // One cycle pulse
   output logic                  stop       // Level
);

   import pktgen_pkg::*;

   csr_data_t   num_packets;
   logic        random_payload;
   csr_data_t   sa0;
   logic [15:0] sa1;
   csr_data_t   da0;
   logic [15:0] da1;
   csr_data_t   seed0;
   csr_data_t   seed1;
   logic [27:0] seed2;       // Only 28 bits of the 92-bit seed live here
   pkt_len_t    pkt_len;
   csr_data_t   tx_pkt_cnt;

   // --------------------
   // Writable registers
   // --------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         num_packets    <= '0;
         random_payload <= 1'b0;
         stop           <= 1'b0;
         sa0            <= '0;
         sa1            <= '0;
         da0            <= '0;
         da1            <= '0;
         seed0          <= `PKTGEN_SEED0_RST;
         seed1          <= `PKTGEN_SEED1_RST;
         seed2          <= 28'(`PKTGEN_SEED2_RST);
         pkt_len        <= '0;
      end else if (write) begin
         case (address)
            `PKTGEN_ADDR_NUMPKTS:     num_packets    <= writedata;
            `PKTGEN_ADDR_RANDPAYLOAD: random_payload <= writedata[0];
            `PKTGEN_ADDR_STOP:        stop           <= writedata[0];
            `PKTGEN_ADDR_MACSA0:      sa0            <= writedata;
            `PKTGEN_ADDR_MACSA1:      sa1            <= writedata[15:0];
            `PKTGEN_ADDR_MACDA0:      da0            <= writedata;
            `PKTGEN_ADDR_MACDA1:      da1            <= writedata[15:0];
            `PKTGEN_ADDR_SEED0:       seed0          <= writedata;
            `PKTGEN_ADDR_SEED1:       seed1          <= writedata;
            `PKTGEN_ADDR_SEED2:       seed2          <= writedata[27:0];
            `PKTGEN_ADDR_PKTLEN:      pkt_len        <= writedata[13:0];
            default: ;                // Read-only or unmapped
         endcase
      end
   end

   // Start self-clears after one cycle
   always_ff @(posedge clk or posedge reset) begin
      if (reset)
         start <= 1'b0;
      else
         start <= write && (address == `PKTGEN_ADDR_START) && writedata[0];
   end

   // Sent packets since last start
   always_ff @(posedge clk or posedge reset) begin
      if (reset)
         tx_pkt_cnt <= '0;
      else if (start)
         tx_pkt_cnt <= '0;
      else if (pkt_done)
         tx_pkt_cnt <= tx_pkt_cnt + 32'd1;
   end

   // --------------------
   // Read-back, valid the cycle after read
   // --------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         readdata <= '0;
      end else if (read) begin
         case (address)
            `PKTGEN_ADDR_NUMPKTS:     readdata <= num_packets;
            `PKTGEN_ADDR_RANDPAYLOAD: readdata <= {31'd0, random_payload};
            `PKTGEN_ADDR_START:       readdata <= {31'd0, start};
            `PKTGEN_ADDR_STOP:        readdata <= {31'd0, stop};
            `PKTGEN_ADDR_MACSA0:      readdata <= sa0;
            `PKTGEN_ADDR_MACSA1:      readdata <= {16'd0, sa1};
            `PKTGEN_ADDR_MACDA0:      readdata <= da0;
            `PKTGEN_ADDR_MACDA1:      readdata <= {16'd0, da1};
            `PKTGEN_ADDR_TXPKTCNT:    readdata <= tx_pkt_cnt;
            `PKTGEN_ADDR_SEED0:       readdata <= seed0;
            `PKTGEN_ADDR_SEED1:       readdata <= seed1;
            `PKTGEN_ADDR_SEED2:       readdata <= {4'd0, seed2};
            `PKTGEN_ADDR_PKTLEN:      readdata <= {18'd0, pkt_len};
            default:                  readdata <= '0;
         endcase
      end
   end

   // Configuration bundle for the datapath
   always_comb begin
      cfg.da             = {da1, da0};
      cfg.sa             = {sa1, sa0};
      cfg.num_packets    = num_packets;
      cfg.pkt_len        = pkt_len;
      cfg.random_payload = random_payload;
      cfg.seed           = {seed2, seed1, seed0};
   end

endmodule

/* hdl/pktgen_pkg.sv */
// --------------------
// Types shared by the packet generator stages. Imported by each
// stage and by the top level.
// --------------------
package pktgen_pkg;

   typedef logic [7:0]  csr_addr_t;  // Register address
   typedef logic [31:0] csr_data_t;  // Register data
   typedef logic [63:0] word_t;      // One stream beat
   typedef logic [2:0]  empty_t;     // Unused bytes in last beat
   typedef logic [47:0] mac_addr_t;
   typedef logic [13:0] pkt_len_t;
   typedef logic [15:0] seq_num_t;
   typedef logic [91:0] prbs_seed_t; // Four 23-bit lanes, lane 0 at the bottom

   // Sequencer states
   typedef enum logic [2:0] {
      IDLE,
      HDR0,   // DA and upper SA
      HDR1,   // Lower SA, length, sequence
      DATA,
      GAP     // One cycle between packets
   } seq_state_t;

   // Static configuration out of the register block
   typedef struct packed {
      mac_addr_t  da;
      mac_addr_t  sa;
      csr_data_t  num_packets;
      pkt_len_t   pkt_len;
      logic       random_payload;
      prbs_seed_t seed;
   } gen_cfg_t;

   // One beat command from sequencer to output stage
   typedef struct packed {
      word_t  hdr_word;  // Used when is_data is low
      logic   is_data;   // Fill from the payload pattern
      logic   sop;
      logic   eop;
      empty_t empty;
      logic   run_first; // First beat after a start
   } beat_cmd_t;

endpackage

/* include/pktgen_macros.svh */
// --------------------
// Register map, reset seeds, length limits and data pattern constants
// for the test packet generator. Included by the RTL that needs them.
// --------------------
`ifndef PKTGEN_MACROS_SVH
`define PKTGEN_MACROS_SVH

// Register addresses
`define PKTGEN_ADDR_NUMPKTS     8'h00
`define PKTGEN_ADDR_RANDPAYLOAD 8'h02
`define PKTGEN_ADDR_START       8'h03
`define PKTGEN_ADDR_STOP        8'h04
`define PKTGEN_ADDR_MACSA0      8'h05
`define PKTGEN_ADDR_MACSA1      8'h06
`define PKTGEN_ADDR_MACDA0      8'h07
`define PKTGEN_ADDR_MACDA1      8'h08
`define PKTGEN_ADDR_TXPKTCNT    8'h09
`define PKTGEN_ADDR_SEED0       8'h0A
`define PKTGEN_ADDR_SEED1       8'h0B
`define PKTGEN_ADDR_SEED2       8'h0C
`define PKTGEN_ADDR_PKTLEN      8'h0D

// Nonzero seeds so the PRBS runs without programming
`define PKTGEN_SEED0_RST 32'h5EED_0000
`define PKTGEN_SEED1_RST 32'h5EED_0001
`define PKTGEN_SEED2_RST 32'h0002_5EED

`define PKTGEN_HDR_BYTES 14'd20   // Bytes taken off the programmed length
`define PKTGEN_MAX_LEN   14'd9600 // Length clamp
`define PKTGEN_SEQ_BYTES 16'd2    // Sequence number counted in length field

// Incrementing byte pattern
`define PKTGEN_INC_FIRST 64'h0001_0203_0405_0607
`define PKTGEN_INC_STEP  64'h0808_0808_0808_0808
`define PKTGEN_INC_LAST  64'hF8F9_FAFB_FCFD_FEFF

`endif
